// File: verilog/core_config_pkg.sv
`default_nettype none

// Sizes shared by the whole core
package core_config_pkg;

    // Width of one general purpose register
    localparam int DATA_WIDTH = 32;

    // Number of architectural registers, r0 included
    localparam int GPR_NUM = 32;

    // Bits needed to name one register
    localparam int REG_ADDR_WIDTH = $clog2(GPR_NUM);

endpackage

`default_nettype wire

// File: verilog/regfile_pkg.sv
`default_nettype none

// Port counts and derived widths of the register file
package regfile_pkg;

    // Default port counts, two writers and four readers
    localparam int DEFAULT_WRITE_PORTS = 2;
    localparam int DEFAULT_READ_PORTS  = 4;

    // Width of one live value table entry
    // A single write port still needs a one bit index
    function automatic int bank_index_width(input int write_ports);
        int width;
        if (write_ports <= 1) begin
            width = 1;
        end else begin
            width = $clog2(write_ports);
        end
        return width;
    endfunction

endpackage

`default_nettype wire

// File: verilog/reg_lutram.sv
`timescale 1ns/1ps
`default_nettype none

// One bank copy of the register set
// Single synchronous write port, single asynchronous read port
module reg_lutram (
    input  logic                                    clk,

    // Write port
    input  logic                                    wen_i,
    input  logic [core_config_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [core_config_pkg::DATA_WIDTH-1:0]     wdata_i,

    // Read port
    input  logic [core_config_pkg::REG_ADDR_WIDTH-1:0] raddr_i,
    output logic [core_config_pkg::DATA_WIDTH-1:0]     rdata_o
);

    import core_config_pkg::*;

    // Register storage, one word per GPR
    logic [DATA_WIDTH-1:0] ram [GPR_NUM];

    // Write on the rising edge
    always_ff @(posedge clk) begin
        if (wen_i) begin
            ram[waddr_i] <= wdata_i;
        end
    end

    // Combinational read
    assign rdata_o = ram[raddr_i];

endmodule

`default_nettype wire

// File: verilog/last_valid_table.sv
`timescale 1ns/1ps
`default_nettype none

// Live value table
// Tracks which write port last wrote each register, so readers know
// which bank holds the current value
module last_valid_table #(
    parameter int WRITE_PORTS = regfile_pkg::DEFAULT_WRITE_PORTS,
    parameter int READ_PORTS  = regfile_pkg::DEFAULT_READ_PORTS
) (
    input  logic clk,
    input  logic arst_n_i,

    // Write side, one entry per write port
    input  logic [WRITE_PORTS-1:0]                                        we_i,
    input  logic [WRITE_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0]   waddr_i,

    // Lookup side, one entry per read port
    input  logic [READ_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0]    raddr_i,
    output logic [READ_PORTS-1:0][regfile_pkg::bank_index_width(WRITE_PORTS)-1:0]
                                                                          live_bank_o
);

    import core_config_pkg::*;
    import regfile_pkg::*;

    localparam int BANK_W = bank_index_width(WRITE_PORTS);

    // One bank index per register
    logic [GPR_NUM-1:0][BANK_W-1:0] lvt_q;

    // Update table
    // Ports are visited in ascending order, so when two ports hit the
    // same register the higher index is the one that sticks
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lvt_q <= '0;
        end else begin
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if (we_i[w]) begin
                    lvt_q[waddr_i[w]] <= BANK_W'(w);
                end
            end
        end
    end

    // Lookup for every read port
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            live_bank_o[r] = lvt_q[raddr_i[r]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/read_resolve.sv
`timescale 1ns/1ps
`default_nettype none

// Read side of the register file
// Picks the live bank copy, then applies bypass, r0 and valid rules
module read_resolve #(
    parameter int WRITE_PORTS = regfile_pkg::DEFAULT_WRITE_PORTS,
    parameter int READ_PORTS  = regfile_pkg::DEFAULT_READ_PORTS
) (
    // Every bank copy, indexed [write port][read port]
    input  logic [WRITE_PORTS-1:0][READ_PORTS-1:0][core_config_pkg::DATA_WIDTH-1:0]
                                                                        bank_rdata_i,

    // Live bank per read port, from the table
    input  logic [READ_PORTS-1:0][regfile_pkg::bank_index_width(WRITE_PORTS)-1:0]
                                                                        live_bank_i,

    // Read request
    input  logic [READ_PORTS-1:0]                                       read_valid_i,
    input  logic [READ_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0]  read_addr_i,

    // Same-cycle writes, used for bypass
    input  logic [WRITE_PORTS-1:0]                                      we_i,
    input  logic [WRITE_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [WRITE_PORTS-1:0][core_config_pkg::DATA_WIDTH-1:0]     wdata_i,

    output logic [READ_PORTS-1:0][core_config_pkg::DATA_WIDTH-1:0]      read_data_o
);

    import core_config_pkg::*;
    import regfile_pkg::*;

    localparam int BANK_W = bank_index_width(WRITE_PORTS);

    // Value from the live bank copy
    logic [READ_PORTS-1:0][DATA_WIDTH-1:0] stored_data;
    // Value after bypass
    logic [READ_PORTS-1:0][DATA_WIDTH-1:0] bypass_data;

    // Bank select
    // Compare against each port index rather than index directly, so a
    // non power of two port count never reaches past the last bank
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            stored_data[r] = bank_rdata_i[0][r];
            for (int w = 1; w < WRITE_PORTS; w++) begin
                if (live_bank_i[r] == BANK_W'(w)) begin
                    stored_data[r] = bank_rdata_i[w][r];
                end
            end
        end
    end

    // Same-cycle bypass, highest matching write port wins
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            bypass_data[r] = stored_data[r];
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if (we_i[w] && (waddr_i[w] == read_addr_i[r])) begin
                    bypass_data[r] = wdata_i[w];
                end
            end
        end
    end

    // Final masking
    // r0 reads zero even while being written, and so does any idle port
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            if (!read_valid_i[r] || (read_addr_i[r] == '0)) begin
                read_data_o[r] = '0;
            end else begin
                read_data_o[r] = bypass_data[r];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/regs_file.sv
`timescale 1ns/1ps
`default_nettype none

// Architectural register file
// Multi-ported storage built from one-write-port banks plus a live value table
module regs_file #(
    parameter int WRITE_PORTS = regfile_pkg::DEFAULT_WRITE_PORTS,
    parameter int READ_PORTS  = regfile_pkg::DEFAULT_READ_PORTS
) (
    input  logic clk,
    input  logic arst_n_i,

    // Write ports
    input  logic [WRITE_PORTS-1:0]                                      we_i,
    input  logic [WRITE_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [WRITE_PORTS-1:0][core_config_pkg::DATA_WIDTH-1:0]     wdata_i,

    // Read ports
    input  logic [READ_PORTS-1:0]                                       read_valid_i,
    input  logic [READ_PORTS-1:0][core_config_pkg::REG_ADDR_WIDTH-1:0]  read_addr_i,
    output logic [READ_PORTS-1:0][core_config_pkg::DATA_WIDTH-1:0]      read_data_o
);

    import core_config_pkg::*;
    import regfile_pkg::*;

    // Every bank copy output, [write port][read port]
    logic [WRITE_PORTS-1:0][READ_PORTS-1:0][DATA_WIDTH-1:0] bank_rdata;

    // Live bank index per read port
    logic [READ_PORTS-1:0][bank_index_width(WRITE_PORTS)-1:0] live_bank;

    // Bank grid
    // Row w is written only by write port w, column r is read only by read port r
    for (genvar w = 0; w < WRITE_PORTS; w++) begin : g_write_bank
        for (genvar r = 0; r < READ_PORTS; r++) begin : g_read_copy
            reg_lutram u_reg_lutram (
                .clk     (clk),
                .wen_i   (we_i[w]),
                .waddr_i (waddr_i[w]),
                .wdata_i (wdata_i[w]),
                .raddr_i (read_addr_i[r]),
                .rdata_o (bank_rdata[w][r])
            );
        end
    end

    // Which bank holds each register's current value
    last_valid_table #(
        .WRITE_PORTS (WRITE_PORTS),
        .READ_PORTS  (READ_PORTS)
    ) u_lvt (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .raddr_i     (read_addr_i),
        .live_bank_o (live_bank)
    );

    // Combine bank data, table result and same-cycle writes
    read_resolve #(
        .WRITE_PORTS (WRITE_PORTS),
        .READ_PORTS  (READ_PORTS)
    ) u_read_resolve (
        .bank_rdata_i (bank_rdata),
        .live_bank_i  (live_bank),
        .read_valid_i (read_valid_i),
        .read_addr_i  (read_addr_i),
        .we_i         (we_i),
        .waddr_i      (waddr_i),
        .wdata_i      (wdata_i),
        .read_data_o  (read_data_o)
    );

endmodule

`default_nettype wire

// File: tests/regfile_model.svh
`ifndef REGFILE_MODEL_SVH
`define REGFILE_MODEL_SVH

// Shadow copy of the architectural registers
logic [DATA_WIDTH-1:0] shadow_regs [GPR_NUM];
// Set once a register has been written since reset
logic [GPR_NUM-1:0]    shadow_written;

task automatic shadow_clear();
    shadow_written = '0;
endtask

// Commit one edge worth of writes
// Ascending order, so the highest port overwrites the others
task automatic shadow_commit(
    input logic [WRITE_PORTS-1:0]                     we_v,
    input logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr_v,
    input logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]     wdata_v
);
    for (int w = 0; w < WRITE_PORTS; w++) begin
        if (we_v[w]) begin
            shadow_regs[waddr_v[w]] = wdata_v[w];
            shadow_written[waddr_v[w]] = 1'b1;
        end
    end
endtask

// Index of the highest enabled write port hitting addr, or -1
function automatic int bypass_port(
    input logic [REG_ADDR_WIDTH-1:0]                  addr,
    input logic [WRITE_PORTS-1:0]                     we_v,
    input logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr_v
);
    int hit;
    hit = -1;
    for (int w = WRITE_PORTS - 1; w >= 0; w--) begin
        if (hit < 0 && we_v[w] && (waddr_v[w] == addr)) begin
            hit = w;
        end
    end
    return hit;
endfunction

// Reads whose result is defined by the rules, stale bank data excluded
function automatic logic read_is_checkable(
    input logic                                       valid,
    input logic [REG_ADDR_WIDTH-1:0]                  addr,
    input logic [WRITE_PORTS-1:0]                     we_v,
    input logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr_v
);
    return !valid || (addr == '0) || (bypass_port(addr, we_v, waddr_v) >= 0)
        || shadow_written[addr];
endfunction

// Expected read data from the shadow array and this cycle's writes
function automatic logic [DATA_WIDTH-1:0] expected_read(
    input logic                                       valid,
    input logic [REG_ADDR_WIDTH-1:0]                  addr,
    input logic [WRITE_PORTS-1:0]                     we_v,
    input logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr_v,
    input logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]     wdata_v
);
    logic [DATA_WIDTH-1:0] value;
    int hit;
    hit = bypass_port(addr, we_v, waddr_v);
    if (!valid || (addr == '0)) begin
        value = '0;
    end else if (hit >= 0) begin
        value = wdata_v[hit];
    end else begin
        value = shadow_regs[addr];
    end
    return value;
endfunction

`endif

// File: tests/regs_file_tb.sv
`timescale 1ns/1ps
`default_nettype none

module regs_file_tb;

    import core_config_pkg::*;
    import regfile_pkg::*;

    localparam int WRITE_PORTS  = DEFAULT_WRITE_PORTS;
    localparam int READ_PORTS   = DEFAULT_READ_PORTS;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;

    // Cycle budget of each test, including its closing idle cycle
    localparam int BASIC_CYCLES    = WRITE_PORTS * 4 * 2 + 1;
    localparam int BYPASS_CYCLES   = WRITE_PORTS * 3 * 2 + 1;
    localparam int CONFLICT_CYCLES = 4 * 4 + 1;
    localparam int R0_CYCLES       = 2 * 2 + 1;
    localparam int INVALID_CYCLES  = 4 + 1;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + 1 + BASIC_CYCLES + BYPASS_CYCLES
                                   + CONFLICT_CYCLES + R0_CYCLES + INVALID_CYCLES
                                   + RANDOM_CYCLES + 1;
    localparam int TIMEOUT_NS      = TOTAL_CYCLES * CLK_PERIOD * 2;

    logic clk = 1'b0;
    logic arst_n;
    logic [WRITE_PORTS-1:0]                     we;
    logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr;
    logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]     wdata;
    logic [READ_PORTS-1:0]                      read_valid;
    logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0]  read_addr;
    logic [READ_PORTS-1:0][DATA_WIDTH-1:0]      read_data;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;

    `include "regfile_model.svh"

    regs_file #(
        .WRITE_PORTS (WRITE_PORTS),
        .READ_PORTS  (READ_PORTS)
    ) DUT (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .we_i         (we),
        .waddr_i      (waddr),
        .wdata_i      (wdata),
        .read_valid_i (read_valid),
        .read_addr_i  (read_addr),
        .read_data_o  (read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Shadow follows the same edge as the DUT
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow_clear();
        end else begin
            shadow_commit(we, waddr, wdata);
        end
    end

    task automatic compare_port(input int r);
        logic [DATA_WIDTH-1:0] expected;
        if (read_is_checkable(read_valid[r], read_addr[r], we, waddr)) begin
            expected = expected_read(read_valid[r], read_addr[r], we, waddr, wdata);
            check_count++;
            if (read_data[r] !== expected) begin
                error_count++;
                $display("Fail read_data_o[%0d] addr %h: got %h, expected %h",
                         r, read_addr[r], read_data[r], expected);
            end
        end
    endtask

    // Outputs are settled mid cycle, well away from the driving edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int r = 0; r < READ_PORTS; r++) begin
                compare_port(r);
            end
        end
    end

    function automatic logic [DATA_WIDTH-1:0] make_word(input int port, input int addr,
                                                        input int salt);
        return DATA_WIDTH'((port + 1) << 24) | DATA_WIDTH'(salt << 8) | DATA_WIDTH'(addr);
    endfunction

    function automatic logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0] same_addr_all(
        input logic [REG_ADDR_WIDTH-1:0] addr
    );
        logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0] ra;
        for (int r = 0; r < READ_PORTS; r++) begin
            ra[r] = addr;
        end
        return ra;
    endfunction

    // Drive one full cycle of inputs on the rising edge
    task automatic apply_cycle(
        input logic [WRITE_PORTS-1:0]                     we_v,
        input logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] waddr_v,
        input logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]     wdata_v,
        input logic [READ_PORTS-1:0]                      valid_v,
        input logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0]  raddr_v
    );
        @(posedge clk);
        we         <= we_v;
        waddr      <= waddr_v;
        wdata      <= wdata_v;
        read_valid <= valid_v;
        read_addr  <= raddr_v;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        we         <= '0;
        read_valid <= '0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name,
                 error_count - errors_before);
    endtask

    task automatic test_basic();
        int errors_before;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        errors_before = error_count;
        for (int w = 0; w < WRITE_PORTS; w++) begin
            for (int k = 0; k < 4; k++) begin
                addr = REG_ADDR_WIDTH'(1 + w * 4 + k);
                wa = '0;
                wd = '0;
                wa[w] = addr;
                wd[w] = make_word(w, int'(addr), 1);
                apply_cycle(WRITE_PORTS'(1 << w), wa, wd, '0, '0);
                apply_cycle('0, wa, wd, '1, same_addr_all(addr));
            end
        end
        drive_idle();
        report_test("basic write and read", errors_before);
    endtask

    task automatic test_bypass();
        int errors_before;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        errors_before = error_count;
        for (int w = 0; w < WRITE_PORTS; w++) begin
            for (int k = 0; k < 3; k++) begin
                addr = REG_ADDR_WIDTH'(20 + w * 3 + k);
                wa = '0;
                wd = '0;
                wa[w] = addr;
                wd[w] = make_word(w, int'(addr), 2);
                apply_cycle(WRITE_PORTS'(1 << w), wa, wd, '1, same_addr_all(addr));
                apply_cycle('0, wa, wd, '1, same_addr_all(addr));
            end
        end
        drive_idle();
        report_test("same-cycle bypass", errors_before);
    endtask

    task automatic test_conflict();
        int errors_before;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        errors_before = error_count;
        for (int k = 0; k < 4; k++) begin
            addr = REG_ADDR_WIDTH'(8 + k);
            for (int w = 0; w < WRITE_PORTS; w++) begin
                wa[w] = addr;
                wd[w] = make_word(w, int'(addr), 3 + k);
            end
            apply_cycle('1, wa, wd, '1, same_addr_all(addr));
            apply_cycle('0, wa, wd, '1, same_addr_all(addr));
            // Port 0 alone takes the register back
            wd[0] = make_word(0, int'(addr), 7);
            apply_cycle(WRITE_PORTS'(1), wa, wd, '1, same_addr_all(addr));
            apply_cycle('0, wa, wd, '1, same_addr_all(addr));
        end
        drive_idle();
        report_test("write conflict", errors_before);
    endtask

    task automatic test_r0();
        int errors_before;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        errors_before = error_count;
        for (int k = 0; k < 2; k++) begin
            for (int w = 0; w < WRITE_PORTS; w++) begin
                wa[w] = '0;
                wd[w] = make_word(w, 0, 9 + k);
            end
            apply_cycle('1, wa, wd, '1, same_addr_all('0));
            apply_cycle('0, wa, wd, '1, same_addr_all('0));
        end
        drive_idle();
        report_test("register r0", errors_before);
    endtask

    task automatic test_invalid();
        int errors_before;
        logic [WRITE_PORTS-1:0] we_v;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        logic [READ_PORTS-1:0] vv;
        logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0] ra;
        errors_before = error_count;
        we_v = '0;
        wa = '0;
        wd = '0;
        for (int r = 0; r < READ_PORTS; r++) begin
            ra[r] = REG_ADDR_WIDTH'(1 + r);
            vv[r] = (r % 2 == 0);
        end
        apply_cycle('0, wa, wd, '0, ra);
        // Bypass hit on an idle port must still read zero
        we_v[WRITE_PORTS-1] = 1'b1;
        wa[WRITE_PORTS-1] = REG_ADDR_WIDTH'(5);
        wd[WRITE_PORTS-1] = make_word(WRITE_PORTS - 1, 5, 11);
        apply_cycle(we_v, wa, wd, '0, same_addr_all(REG_ADDR_WIDTH'(5)));
        wd[WRITE_PORTS-1] = make_word(WRITE_PORTS - 1, 5, 12);
        apply_cycle(we_v, wa, wd, vv, same_addr_all(REG_ADDR_WIDTH'(5)));
        apply_cycle('0, wa, wd, '1, same_addr_all(REG_ADDR_WIDTH'(5)));
        drive_idle();
        report_test("invalid reads", errors_before);
    endtask

    task automatic test_random();
        int errors_before;
        logic [WRITE_PORTS-1:0] we_v;
        logic [WRITE_PORTS-1:0][REG_ADDR_WIDTH-1:0] wa;
        logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wd;
        logic [READ_PORTS-1:0] vv;
        logic [READ_PORTS-1:0][REG_ADDR_WIDTH-1:0] ra;
        errors_before = error_count;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int w = 0; w < WRITE_PORTS; w++) begin
                we_v[w] = 1'($urandom_range(1, 0));
                wa[w] = REG_ADDR_WIDTH'($urandom_range(GPR_NUM - 1, 0));
                wd[w] = DATA_WIDTH'($urandom);
            end
            for (int r = 0; r < READ_PORTS; r++) begin
                vv[r] = ($urandom_range(3, 0) != 0);
                // Aim a quarter of the reads at a write address to hit bypass
                if ($urandom_range(3, 0) == 0) begin
                    ra[r] = wa[$urandom_range(WRITE_PORTS - 1, 0)];
                end else begin
                    ra[r] = REG_ADDR_WIDTH'($urandom_range(GPR_NUM - 1, 0));
                end
            end
            apply_cycle(we_v, wa, wd, vv, ra);
        end
        drive_idle();
        report_test("random mix", errors_before);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(83));
        arst_n     <= 1'b0;
        we         <= '0;
        waddr      <= '0;
        wdata      <= '0;
        read_valid <= '0;
        read_addr  <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        test_basic();
        test_bypass();
        test_conflict();
        test_r0();
        test_invalid();
        test_random();

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            if (check_count == 0) begin
                $display("No read result was compared during the run");
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+tests
verilog/core_config_pkg.sv
verilog/regfile_pkg.sv
verilog/reg_lutram.sv
verilog/last_valid_table.sv
verilog/read_resolve.sv
verilog/regs_file.sv
tests/regs_file_tb.sv

// File: Makefile
# Verilator flow for the multi-ported register file
# Every variable below can be overridden on the command line

VERILATOR  ?= verilator
FILE_LIST  ?= files.f
TB_TOP     ?= regs_file_tb
RTL_TOP    ?= regs_file
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed

RTL_SRCS   ?= verilog/core_config_pkg.sv \
              verilog/regfile_pkg.sv \
              verilog/reg_lutram.sv \
              verilog/last_valid_table.sv \
              verilog/read_resolve.sv \
              verilog/regs_file.sv
TB_SRCS    ?= tests/regs_file_tb.sv tests/regfile_model.svh

LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing

SIM_BIN    := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
